//--- parking_settings.svh
// Sizes and fee constants for the parking lot
// Included by the package and by every module that sizes itself from these values
`ifndef PARKING_SETTINGS_SVH
`define PARKING_SETTINGS_SVH

// Parking floors above the entrance, two spots each
`define FLOORS 7

`define PLATE_W 16 // License plate width
`define QUEUE_DEPTH 8 // Order queue entries
`define FEE_W 8 // Fee width, saturates at all ones

// Top nibble of the plate selects the rate class
`define HANDICAP_PREFIX 4'b1001
`define HYBRID_PREFIX 4'b1000

// Rate per parked cycle, handicapped cars pay nothing
`define HYBRID_RATE 2'd1
`define STANDARD_RATE 2'd2

`endif

//--- parking_pkg.sv
// Shared types of the parking lot: plates, spots, orders, fees and elevator states
// Modules pull these in with a wildcard import in their header
`default_nettype none

`include "parking_settings.svh"

package parking_pkg;

	// License plate, zero means no car
	typedef logic [`PLATE_W-1:0] plate_t;

	// Floor 1 to 7, place 0 is left and 1 is right
	typedef struct packed {
		logic [2:0] floor;
		logic place;
	} spot_t;

	typedef enum logic {
		order_park = 1'b0,
		order_retrieve = 1'b1
	} order_kind_t;

	typedef struct packed {
		order_kind_t kind;
		plate_t plate;
	} order_t;

	typedef logic [`FEE_W-1:0] fee_t;

	typedef enum logic [2:0] {
		el_idle, // At floor 0, ready for the next order
		el_rise,
		el_park, // Arrival cycle of a park order
		el_fetch, // Arrival cycle of a retrieve order
		el_descend
	} elevator_state_t;

endpackage

`default_nettype wire

//--- order_fifo.sv
// Circular order queue between the order strobes and the elevator
// Head always shows the oldest order, pushes while full are dropped
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module order_fifo import parking_pkg::*; #(
	parameter int DEPTH = `QUEUE_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic push,
	input order_t push_order,
	input logic pop,
	output order_t head,
	output logic empty,
	output logic full
);
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	order_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign head = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_order;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop keeps the count
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- space_allocator.sv
// Combinational spot search: a free spot of the plate's class for parking,
// and the spot that holds the plate for retrieval
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module space_allocator import parking_pkg::*; (
	input plate_t plate,
	input plate_t [2*`FLOORS-1:0] occupied, // Index is (floor - 1) * 2 + place
	output spot_t free_spot,
	output logic free_found,
	output spot_t held_spot,
	output logic held_found
);
	localparam int SPOTS = 2 * `FLOORS;

	logic sedan_full; // All even floor spots taken
	logic [SPOTS-1:0] allowed; // Spots open to this plate's class

	// Sedans spill onto odd floors only once their own floors are full
	always_comb begin
		sedan_full = 1'b1;
		for (int i = 0; i < SPOTS; i++) begin
			if (((i / 2) % 2) == 1 && occupied[i] == '0)
				sedan_full = 1'b0;
		end
		for (int i = 0; i < SPOTS; i++) begin
			if (plate[0])
				allowed[i] = ((i / 2) % 2) == 0; // SUV, odd floors
			else
				allowed[i] = ((i / 2) % 2) == 1 || sedan_full;
		end
	end

	// Index order already walks floors upward, left before right
	always_comb begin
		free_found = 1'b0;
		free_spot = '0;
		held_found = 1'b0;
		held_spot = '0;
		for (int i = 0; i < SPOTS; i++) begin
			if (!free_found && plate != '0 && allowed[i] && occupied[i] == '0) begin
				free_found = 1'b1;
				free_spot.floor = 3'(i / 2 + 1);
				free_spot.place = 1'(i % 2);
			end
			if (!held_found && plate != '0 && occupied[i] == plate) begin
				held_found = 1'b1;
				held_spot.floor = 3'(i / 2 + 1);
				held_spot.place = 1'(i % 2);
			end
		end
	end

endmodule

`default_nettype wire

//--- fee_meter.sv
// Parked-cycle counter and fee for one spot
// start clears the count when a car is stored, fee is valid while the car is there
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module fee_meter import parking_pkg::*; (
	input logic clock,
	input logic reset,
	input logic start,
	input logic occupied,
	input plate_t plate,
	output fee_t fee
);
	logic [`FEE_W-1:0] count; // Saturates, fee is capped anyway
	logic [`FEE_W:0] elapsed;
	logic [`FEE_W+1:0] charge;
	logic [1:0] rate;

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			count <= '0;
		else if (start)
			count <= '0;
		else if (occupied && count != '1)
			count <= count + 1'b1;
	end

	always_comb begin
		if (plate[`PLATE_W-1 -: 4] == `HANDICAP_PREFIX)
			rate = 2'd0;
		else if (plate[`PLATE_W-1 -: 4] == `HYBRID_PREFIX)
			rate = `HYBRID_RATE;
		else
			rate = `STANDARD_RATE;
		elapsed = (`FEE_W+1)'(count) + 1'b1; // Current cycle counts too
		charge = (`FEE_W+2)'(elapsed) * (`FEE_W+2)'(rate);
		fee = (|charge[`FEE_W+1 -: 2]) ? '1 : charge[`FEE_W-1:0];
	end

endmodule

`default_nettype wire

//--- spot_table.sv
// Plates parked in all 14 spots, with a fee meter per spot
// Store and remove address one spot, the removed car's plate and fee come back at once
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module spot_table import parking_pkg::*; (
	input logic clock,
	input logic reset,
	input logic store,
	input logic remove,
	input spot_t spot,
	input plate_t store_plate,
	output plate_t [2*`FLOORS-1:0] occupied,
	output plate_t removed_plate,
	output fee_t removed_fee
);
	localparam int SPOTS = 2 * `FLOORS;
	localparam int IDX_W = $clog2(SPOTS);

	logic [IDX_W-1:0] idx;
	logic idx_valid;
	fee_t [SPOTS-1:0] fees;

	assign idx = {spot.floor - 3'd1, spot.place}; // Floor 1 left is spot 0
	assign idx_valid = (spot.floor != 3'd0) && (idx < IDX_W'(SPOTS));

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			occupied <= '0;
		end else if (idx_valid) begin
			if (store)
				occupied[idx] <= store_plate;
			else if (remove)
				occupied[idx] <= '0;
		end
	end

	genvar g;
	generate
		for (g = 0; g < SPOTS; g++) begin : g_meter
			fee_meter u_meter (
				.clock(clock),
				.reset(reset),
				.start(store && idx_valid && idx == IDX_W'(g)),
				.occupied(occupied[g] != '0),
				.plate(occupied[g]),
				.fee(fees[g])
			);
		end
	endgenerate

	// Addressed spot, read before the remove edge clears it
	always_comb begin
		if (idx_valid) begin
			removed_plate = occupied[idx];
			removed_fee = fees[idx];
		end else begin
			removed_plate = '0;
			removed_fee = '0;
		end
	end

endmodule

`default_nettype wire

//--- elevator_controller.sv
// Elevator FSM: takes one order at floor 0, rises a floor per cycle, parks or fetches,
// then descends and hands the fetched car out one cycle after reaching floor 0
`timescale 1ns/1ps
`default_nettype none

module elevator_controller import parking_pkg::*; (
	input logic clock,
	input logic reset,
	input logic empty,
	input order_t head,
	input spot_t free_spot,
	input logic free_found,
	input spot_t held_spot,
	input logic held_found,
	input plate_t removed_plate,
	input fee_t removed_fee,
	output logic pop,
	output logic store,
	output logic remove,
	output spot_t spot,
	output plate_t store_plate,
	output logic [2:0] current_floor,
	output logic parked,
	output logic car_out,
	output plate_t car_out_plate,
	output fee_t fee,
	output logic rejected
);
	elevator_state_t state;
	order_kind_t kind; // Order in service
	spot_t target;
	logic accept;
	elevator_state_t dock; // Arrival state for the head order

	assign pop = (state == el_idle) && !empty;
	assign store = (state == el_park);
	assign remove = (state == el_fetch);
	assign parked = store; // Spot is reported with the store

	// Plate 0 never finds a spot, so it falls out as a reject here
	always_comb begin
		if (head.kind == order_park) begin
			target = free_spot;
			accept = free_found;
			dock = el_park;
		end else begin
			target = held_spot;
			accept = held_found;
			dock = el_fetch;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= el_idle;
			kind <= order_park;
			current_floor <= 3'd0;
			rejected <= 1'b0;
			car_out <= 1'b0;
		end else begin
			rejected <= 1'b0;
			car_out <= 1'b0;
			case (state)
				el_idle: begin
					if (pop) begin
						kind <= head.kind;
						if (!accept) begin
							rejected <= 1'b1; // Stay at floor 0
						end else begin
							current_floor <= 3'd1;
							state <= (target.floor == 3'd1) ? dock : el_rise;
						end
					end
				end
				el_rise: begin
					current_floor <= current_floor + 3'd1;
					if (current_floor + 3'd1 == spot.floor)
						state <= (kind == order_park) ? el_park : el_fetch;
				end
				el_park, el_fetch: begin
					current_floor <= current_floor - 3'd1;
					state <= el_descend;
				end
				el_descend: begin
					if (current_floor == 3'd0) begin
						state <= el_idle;
						car_out <= (kind == order_retrieve);
					end else begin
						current_floor <= current_floor - 3'd1;
					end
				end
				default: state <= el_idle;
			endcase
		end
	end

	// Order payload and the fetched car
	always_ff @(posedge clock) begin
		if (pop) begin
			spot <= target;
			store_plate <= head.plate;
		end
		if (remove) begin
			car_out_plate <= removed_plate;
			fee <= removed_fee;
		end
	end

endmodule

`default_nettype wire

//--- parking_lot_top.sv
// Parking lot top level: order queue, spot search, spot table and elevator
// in_mode parks and out_mode retrieves the car with license_plate
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module parking_lot_top import parking_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_mode,
	input logic out_mode,
	input plate_t license_plate,
	output logic queue_full,
	output logic [2:0] current_floor,
	output logic parked,
	output spot_t parked_spot,
	output logic car_out,
	output plate_t car_out_plate,
	output fee_t fee,
	output logic rejected
);
	order_t push_order;
	order_t head;
	logic empty;
	logic pop;
	plate_t [2*`FLOORS-1:0] occupied;
	spot_t free_spot;
	logic free_found;
	spot_t held_spot;
	logic held_found;
	logic store;
	logic remove;
	plate_t store_plate;
	plate_t removed_plate;
	fee_t removed_fee;

	// Retrieve wins if both strobes come together
	assign push_order = '{kind: out_mode ? order_retrieve : order_park, plate: license_plate};

	order_fifo u_queue (
		.clock(clock),
		.reset(reset),
		.push(in_mode || out_mode),
		.push_order(push_order),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(queue_full)
	);

	space_allocator u_alloc (
		.plate(head.plate),
		.occupied(occupied),
		.free_spot(free_spot),
		.free_found(free_found),
		.held_spot(held_spot),
		.held_found(held_found)
	);

	spot_table u_table (
		.clock(clock),
		.reset(reset),
		.store(store),
		.remove(remove),
		.spot(parked_spot),
		.store_plate(store_plate),
		.occupied(occupied),
		.removed_plate(removed_plate),
		.removed_fee(removed_fee)
	);

	elevator_controller u_elevator (
		.clock(clock),
		.reset(reset),
		.empty(empty),
		.head(head),
		.free_spot(free_spot),
		.free_found(free_found),
		.held_spot(held_spot),
		.held_found(held_found),
		.removed_plate(removed_plate),
		.removed_fee(removed_fee),
		.pop(pop),
		.store(store),
		.remove(remove),
		.spot(parked_spot), // Target spot, also the table address
		.store_plate(store_plate),
		.current_floor(current_floor),
		.parked(parked),
		.car_out(car_out),
		.car_out_plate(car_out_plate),
		.fee(fee),
		.rejected(rejected)
	);

endmodule

`default_nettype wire

//--- parking_lot_sva.sv
// Concurrent checks bound to the parking lot top level
// Covers floor range and steps, clashing output pulses and pushes into a full queue
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module parking_lot_sva (
	input logic clock,
	input logic reset,
	input logic in_mode,
	input logic out_mode,
	input logic queue_full,
	input logic [2:0] current_floor,
	input logic parked,
	input logic car_out
);
	int fail_count = 0; // Failed assertions so far

	// A rise past the top floor would wrap the floor count to 0
	floor_in_range: assert property (@(posedge clock) disable iff (reset)
		(current_floor == 3'(`FLOORS)) |=> (current_floor != 3'd0))
	else begin
		fail_count++;
		$error("elevator rose past floor %0d", `FLOORS);
	end

	// One floor per cycle at most
	floor_step: assert property (@(posedge clock) disable iff (reset)
		(int'(current_floor) - int'($past(current_floor)) <= 1)
		&& (int'($past(current_floor)) - int'(current_floor) <= 1))
	else begin
		fail_count++;
		$error("elevator moved more than one floor in a cycle, now at floor %0d",
			current_floor);
	end

	park_fetch_apart: assert property (@(posedge clock) disable iff (reset)
		!(parked && car_out))
	else begin
		fail_count++;
		$error("parked and car_out asserted together");
	end

	no_push_when_full: assert property (@(posedge clock) disable iff (reset)
		!((in_mode || out_mode) && queue_full))
	else begin
		fail_count++;
		$error("order strobe while the queue is full");
	end

endmodule

bind parking_lot_top parking_lot_sva u_sva (
	.clock(clock),
	.reset(reset),
	.in_mode(in_mode),
	.out_mode(out_mode),
	.queue_full(queue_full),
	.current_floor(current_floor),
	.parked(parked),
	.car_out(car_out)
);

`default_nettype wire

//--- tb_parking_lot.sv
// Parking lot testbench that replays the order list from the stimulus file as a burst
// and checks every parked spot, rejection, fetched plate and fee in arrival order
`timescale 1ns/1ps
`default_nettype none

`include "parking_settings.svh"

module tb_parking_lot import parking_pkg::*; ();
	localparam int MAX_ORDERS = 64;

	logic clock;
	logic reset;
	logic in_mode;
	logic out_mode;
	plate_t license_plate;
	logic queue_full;
	logic [2:0] current_floor;
	logic parked;
	spot_t parked_spot;
	logic car_out;
	plate_t car_out_plate;
	fee_t fee;
	logic rejected;

	logic [31:0] stim [MAX_ORDERS]; // Hex nibbles kind, plate, reject flag, floor and place
	int num_orders;
	int checked; // Orders whose response has been seen
	int cycle = 0;
	bit loaded = 1'b0;
	int park_cycle [65536]; // Cycle of the parked pulse for each plate

	parking_lot_top DUT (
		.clock(clock),
		.reset(reset),
		.in_mode(in_mode),
		.out_mode(out_mode),
		.license_plate(license_plate),
		.queue_full(queue_full),
		.current_floor(current_floor),
		.parked(parked),
		.parked_spot(parked_spot),
		.car_out(car_out),
		.car_out_plate(car_out_plate),
		.fee(fee),
		.rejected(rejected)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
		cycle <= cycle + 1;

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	// Expected fee for a stay of the given number of cycles
	function automatic int expected_fee(input plate_t plate, input int stay);
		int rate;
		int total;
		if (plate[15:12] == `HANDICAP_PREFIX)
			rate = 0;
		else if (plate[15:12] == `HYBRID_PREFIX)
			rate = 1;
		else
			rate = 2;
		total = rate * stay;
		return (total > 255) ? 255 : total;
	endfunction

	// Matches one response pulse against the next order of the list
	task automatic check_response();
		int i;
		logic [3:0] kind;
		plate_t plate;
		int exp_floor;
		int exp_place;
		int stay;
		i = checked;
		assert ($onehot({parked, car_out, rejected}))
		else stop_with_error("Several response pulses came in the same cycle");
		assert (i < num_orders)
		else stop_with_error("A response pulse came with no order left to answer");
		kind = stim[i][31:28];
		plate = stim[i][27:12];
		exp_floor = int'(stim[i][7:4]);
		exp_place = int'(stim[i][3:0]);
		if (stim[i][11:8] != 4'd0) begin
			assert (rejected)
			else stop_with_error($sformatf("Fail at time %0t: order %0d plate %h not rejected",
				$time, i, plate));
		end else if (kind == 4'd0) begin
			assert (parked)
			else stop_with_error($sformatf("Fail at time %0t: order %0d plate %h not parked",
				$time, i, plate));
			assert (int'(parked_spot.floor) == exp_floor && int'(parked_spot.place) == exp_place)
			else stop_with_error($sformatf("Fail at time %0t: plate %h parked at %0d/%0d, not %0d/%0d",
				$time, plate, parked_spot.floor, parked_spot.place, exp_floor, exp_place));
			park_cycle[plate] = cycle;
		end else begin
			stay = cycle - park_cycle[plate] - (exp_floor + 1); // Store to removal
			assert (car_out)
			else stop_with_error($sformatf("Fail at time %0t: order %0d plate %h not fetched",
				$time, i, plate));
			assert (car_out_plate == plate)
			else stop_with_error($sformatf("Fail at time %0t: car out plate %h, expected %h",
				$time, car_out_plate, plate));
			assert (int'(parked_spot.floor) == exp_floor && int'(parked_spot.place) == exp_place)
			else stop_with_error($sformatf("Fail at time %0t: plate %h fetched from %0d/%0d",
				$time, plate, parked_spot.floor, parked_spot.place));
			assert (int'(fee) == expected_fee(plate, stay))
			else stop_with_error($sformatf("Fail at time %0t: plate %h fee %0d, expected %0d",
				$time, plate, fee, expected_fee(plate, stay)));
		end
		checked = checked + 1;
	endtask

	// Outputs are sampled mid-cycle away from the clock edge
	always @(negedge clock) begin
		if (!reset && (parked || car_out || rejected))
			check_response();
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		in_mode = 1'b0;
		out_mode = 1'b0;
		license_plate = '0;
		checked = 0;
		for (int i = 0; i < MAX_ORDERS; i++)
			stim[i] = {4'hf, 28'(i)}; // Kind f marks words past the end of the list
		$readmemh("parking_stim.mem", stim);
		num_orders = 0;
		while (num_orders < MAX_ORDERS && stim[num_orders][31:28] <= 4'd1)
			num_orders++;
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		assert (!parked && !car_out && !rejected && current_floor == 3'd0 && !queue_full)
		else stop_with_error("Outputs are not idle after reset");

		// Back to back orders that wait only while the queue is full
		for (int i = 0; i < num_orders; i++) begin
			while (queue_full) begin
				@(posedge clock);
				#1;
			end
			in_mode = (stim[i][31:28] == 4'd0);
			out_mode = (stim[i][31:28] == 4'd1);
			license_plate = stim[i][27:12];
			@(posedge clock);
			#1;
			in_mode = 1'b0;
			out_mode = 1'b0;
		end
		wait (checked == num_orders);
		repeat (10) @(posedge clock); // Room for a stray pulse to show up
		if (DUT.u_sva.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_with_error($sformatf("%0d concurrent assertions on the top level failed",
				DUT.u_sva.fail_count));
		end
	end

	// Watchdog
	initial begin
		wait (loaded);
		repeat (num_orders * 40 + 200) @(posedge clock);
		stop_with_error($sformatf("Timeout with %0d of %0d orders answered",
			checked, num_orders));
	end

endmodule

`default_nettype wire

//--- parking_stim.mem
// One order per hex word: kind (0 park, 1 retrieve), plate, reject flag, floor, place
// Floor and place give the spot a park fills or a retrieve empties, zero for rejects
0_1001_0_1_0
0_2002_0_2_0
0_8003_0_1_1
0_9004_0_2_1
0_3006_0_4_0
0_4008_0_4_1
0_500a_0_6_0
0_600c_0_6_1
0_700e_0_3_0
0_a011_0_3_1
0_b013_0_5_0
0_c015_0_5_1
0_d017_0_7_0
0_e019_0_7_1
0_f01b_1_0_0
0_f01c_1_0_0
0_0000_1_0_0
1_1234_1_0_0
1_0000_1_0_0
1_8003_0_1_1
1_9004_0_2_1
1_2002_0_2_0
1_1001_0_1_0
0_2020_0_2_0
1_2020_0_2_0

//--- sources.f
+incdir+.
parking_pkg.sv
order_fifo.sv
space_allocator.sv
fee_meter.sv
spot_table.sv
elevator_controller.sv
parking_lot_top.sv
parking_lot_sva.sv
tb_parking_lot.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_parking_lot -f sources.f
	@out=$$(./obj_dir/Vtb_parking_lot 2>&1); echo "$$out"; \
	echo "$$out" | grep -q '^Simulation finished: PASS$$'

clean:
	rm -rf obj_dir
